//--- logic/div_control.sv
// Divider sequencing
//   Control FSM idle / check / run / fix / done
//   Step counter for the shift-subtract loop
//   Busy, done, flush handling and datapath strobes
module div_control
   import div_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic req_valid,
   input  logic flush,
   input  logic small_hit,
   output logic busy,
   output logic done,
   output logic load,
   output logic run_step,
   output logic fix_step,
   output logic out_load,
   output logic use_small
);

   div_state_t state, state_nxt;
   count_t     count;
   logic       last_step;

   assign last_step = (count == count_t'(DIV_STEPS - 1));

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle:  if (req_valid) state_nxt = st_check;
         st_check: state_nxt = small_hit ? st_done : st_run;
         st_run:   if (last_step) state_nxt = st_fix;
         st_fix:   state_nxt = st_done;
         st_done:  state_nxt = st_idle;
         default:  state_nxt = st_idle;
      endcase
      // Flush drops the operation, but not once done is showing
      if (flush && state != st_done) begin
         state_nxt = st_idle;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
         count <= '0;
      end else begin
         state <= state_nxt;
         if (state == st_run) begin
            count <= count + count_t'(1);
         end else begin
            count <= '0;   // Ready for the next run
         end
      end
   end

   assign busy     = (state != st_idle);
   assign done     = (state == st_done);
   assign load     = (state == st_idle) && req_valid;
   assign run_step = (state == st_run);
   assign fix_step = (state == st_fix);

   // Shortcut taken straight out of the check cycle
   assign use_small = (state == st_check) && small_hit;

   // Result register loads in the cycle before done
   assign out_load = (use_small || state == st_fix) && !flush;

endmodule

//--- logic/div_datapath.sv
// Divider datapath
//   Raw operand and operation registers
//   Magnitude conversion and sign flags for signed ops
//   Non-restoring shift/subtract loop, one bit per step
//   Remainder correction
module div_datapath
   import div_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    load,
   input  logic    run_step,
   input  logic    fix_step,
   input  div_op_t req_op,
   input  data_t   dividend,
   input  data_t   divisor,
   output data_t   opa,
   output data_t   opb,
   output logic    is_rem,
   output logic    neg_quot,
   output logic    neg_rem,
   output data_t   quot,
   output data_t   rem
);

   div_op_t op_q;
   data_t   mag_b;      // Divisor magnitude
   acc_t    acc;        // Partial remainder
   data_t   quot_q;

   logic    sign_eff;
   data_t   mag_a_in;
   data_t   mag_b_in;
   acc_t    acc_sh;
   acc_t    acc_nxt;
   acc_t    acc_fix;

   // Signed handling only when the divisor is nonzero
   // so a divide by zero returns the raw dividend
   assign sign_eff = ((req_op == op_div) || (req_op == op_rem)) && (divisor != '0);

   assign mag_a_in = (sign_eff && dividend[DIV_W-1]) ? -dividend : dividend;
   assign mag_b_in = (sign_eff && divisor[DIV_W-1])  ? -divisor  : divisor;

   // Shift in the next dividend bit, then add or subtract by sign
   assign acc_sh  = {acc[DIV_W-1:0], quot_q[DIV_W-1]};
   assign acc_nxt = acc[DIV_W] ? acc_sh + {1'b0, mag_b}
                               : acc_sh - {1'b0, mag_b};

   // Negative final remainder gets the divisor added back
   assign acc_fix = acc[DIV_W] ? acc + {1'b0, mag_b} : acc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         op_q     <= op_div;
         neg_quot <= 1'b0;
         neg_rem  <= 1'b0;
      end else if (load) begin
         op_q     <= req_op;
         neg_quot <= sign_eff && (dividend[DIV_W-1] ^ divisor[DIV_W-1]);
         neg_rem  <= sign_eff && dividend[DIV_W-1];   // Remainder follows dividend
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         opa    <= dividend;
         opb    <= divisor;
         mag_b  <= mag_b_in;
         quot_q <= mag_a_in;   // Dividend bits shift out of the top
         acc    <= '0;
      end else if (run_step) begin
         acc    <= acc_nxt;
         quot_q <= {quot_q[DIV_W-2:0], ~acc_nxt[DIV_W]};
      end else if (fix_step) begin
         acc    <= acc_fix;
      end
   end

   assign is_rem = (op_q == op_rem) || (op_q == op_remu);
   assign quot   = quot_q;
   assign rem    = acc_fix[DIV_W-1:0];   // Already corrected in the fix cycle

endmodule

//--- logic/div_pkg.sv
// Shared definitions for the iterative divider
//   DIV_W, DIV_STEPS  operand width and loop length
//   data_t, acc_t     operand word and partial remainder
//   count_t           loop step counter
//   div_op_t          operation encoding
//   div_state_t       control FSM states
package div_pkg;

   parameter int DIV_W     = 32;
   parameter int DIV_STEPS = 32;      // One quotient bit per step

   typedef logic [DIV_W-1:0] data_t;
   typedef logic [DIV_W:0]   acc_t;   // Top bit is the running sign
   typedef logic [5:0]       count_t;

   // Bit 1 selects remainder, bit 0 selects unsigned
   typedef enum logic [1:0] {
      op_div  = 2'b00,
      op_divu = 2'b01,
      op_rem  = 2'b10,
      op_remu = 2'b11
   } div_op_t;

   typedef enum logic [2:0] {
      st_idle  = 3'd0,
      st_check = 3'd1,   // Shortcut decision
      st_run   = 3'd2,
      st_fix   = 3'd3,   // Remainder correction
      st_done  = 3'd4
   } div_state_t;

endpackage

//--- logic/div_result.sv
// Result stage
//   Sign fix of quotient and remainder
//   Selection of shortcut, remainder or quotient
//   Output register loaded the cycle before done
module div_result
   import div_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  out_load,
   input  logic  use_small,
   input  logic  is_rem,
   input  logic  neg_quot,
   input  logic  neg_rem,
   input  data_t quot,
   input  data_t rem,
   input  data_t small_quot,
   output data_t result
);

   data_t quot_fix;
   data_t rem_fix;
   data_t result_nxt;

   // Overflow case lands here as 0x80000000 with no negation
   assign quot_fix = neg_quot ? -quot : quot;
   assign rem_fix  = neg_rem  ? -rem  : rem;

   always_comb begin
      if (use_small) begin
         result_nxt = small_quot;
      end else if (is_rem) begin
         result_nxt = rem_fix;
      end else begin
         result_nxt = quot_fix;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         result <= '0;
      end else if (out_load) begin
         result <= result_nxt;   // Held until the next load
      end
   end

endmodule

//--- logic/div_small.sv
// Small-number shortcut
//   Hit detection on the registered operands
//   Unsigned quotient at SMALL_W bits
module div_small
   import div_pkg::*;
#(
   parameter int SMALL_W = 4
) (
   input  data_t opa,
   input  data_t opb,
   input  logic  is_rem,
   output logic  small_hit,
   output data_t small_quot
);

   logic [SMALL_W-1:0] a_s;
   logic [SMALL_W-1:0] b_s;
   logic [SMALL_W-1:0] b_div;
   logic [SMALL_W-1:0] q_s;
   logic               a_fits;
   logic               b_fits;

   assign a_fits = ((opa >> SMALL_W) == '0);
   assign b_fits = ((opb >> SMALL_W) == '0);

   // Negative signed operands never fit, so unsigned math is enough
   assign small_hit = !is_rem && a_fits && b_fits && (opb != '0);

   assign a_s = opa[SMALL_W-1:0];
   assign b_s = opb[SMALL_W-1:0];

   // Zero divisor is a miss anyway
   assign b_div = (b_s == '0) ? SMALL_W'(1) : b_s;
   assign q_s   = a_s / b_div;

   assign small_quot = {{(DIV_W-SMALL_W){1'b0}}, q_s};

endmodule

//--- logic/div_top.sv
// Iterative 32-bit divider top level
//   Control FSM, datapath, small-number shortcut, result stage
//   Request accepted on req_valid while not busy
//   done pulses one cycle with result registered
module div_top
   import div_pkg::*;
#(
   parameter int SMALL_W = 4
) (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    req_valid,
   input  div_op_t req_op,
   input  data_t   dividend,
   input  data_t   divisor,
   input  logic    flush,
   output logic    busy,
   output logic    done,
   output data_t   result
);

   logic  load;
   logic  run_step;
   logic  fix_step;
   logic  out_load;
   logic  use_small;
   logic  small_hit;
   logic  is_rem;
   logic  neg_quot;
   logic  neg_rem;
   data_t opa;
   data_t opb;
   data_t quot;
   data_t rem;
   data_t small_quot;

   div_control u_control (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .flush     (flush),
      .small_hit (small_hit),
      .busy      (busy),
      .done      (done),
      .load      (load),
      .run_step  (run_step),
      .fix_step  (fix_step),
      .out_load  (out_load),
      .use_small (use_small)
   );

   div_datapath u_datapath (
      .clk      (clk),
      .rst_n    (rst_n),
      .load     (load),
      .run_step (run_step),
      .fix_step (fix_step),
      .req_op   (req_op),
      .dividend (dividend),
      .divisor  (divisor),
      .opa      (opa),
      .opb      (opb),
      .is_rem   (is_rem),
      .neg_quot (neg_quot),
      .neg_rem  (neg_rem),
      .quot     (quot),
      .rem      (rem)
   );

   div_small #(
      .SMALL_W (SMALL_W)
   ) u_small (
      .opa        (opa),
      .opb        (opb),
      .is_rem     (is_rem),
      .small_hit  (small_hit),
      .small_quot (small_quot)
   );

   div_result u_result (
      .clk        (clk),
      .rst_n      (rst_n),
      .out_load   (out_load),
      .use_small  (use_small),
      .is_rem     (is_rem),
      .neg_quot   (neg_quot),
      .neg_rem    (neg_rem),
      .quot       (quot),
      .rem        (rem),
      .small_quot (small_quot),
      .result     (result)
   );

endmodule

//--- src.f
logic/div_pkg.sv
logic/div_control.sv
logic/div_datapath.sv
logic/div_small.sv
logic/div_result.sv
logic/div_top.sv
tests/div_clk_gen.sv
tests/div_sva.sv
tests/div_tb.sv

//--- tests/div_clk_gen.sv
// Testbench clock source
//   Free-running clock, period set by parameter
module div_clk_gen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

//--- tests/div_sva.sv
// Bound checks on the divider control
//   done never high on two cycles in a row
//   busy rises one cycle after an accept
//   no done between a flush and the next accept
module div_sva
   import div_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic req_valid,
   input logic flush,
   input logic busy,
   input logic done
);

   int   fail_count = 0;   // Read by the testbench at the end
   logic flushed;          // Operation dropped, no accept since

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         flushed <= 1'b0;
      end else if (flush && !done) begin
         flushed <= 1'b1;
      end else if (req_valid && !busy) begin
         flushed <= 1'b0;
      end
   end

   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         fail_count++;
         $error("done high on two cycles in a row");
      end

   a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
      (req_valid && !busy && !flush) |=> busy)
      else begin
         fail_count++;
         $error("busy did not rise after an accept");
      end

   a_no_done_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
      flushed |-> !done)
      else begin
         fail_count++;
         $error("done after a flush without a new accept");
      end

endmodule

bind div_control div_sva u_sva (
   .clk       (clk),
   .rst_n     (rst_n),
   .req_valid (req_valid),
   .flush     (flush),
   .busy      (busy),
   .done      (done)
);

//--- tests/div_tb.sv
// Testbench for the iterative divider
//   Random, shortcut, divide by zero and overflow operations
//   Flush sequences and requests made while busy
//   ref_div model, result and latency checks at each done
//   Cycle-count timeout and closing report
module div_tb
   import div_pkg::*;
();

   localparam int SMALL_W        = 4;
   localparam int SMALL_MAX      = (1 << SMALL_W) - 1;
   localparam int SHORT_LAT      = 2;    // Accept to done, shortcut
   localparam int LONG_LAT       = 35;   // Check, 32 steps, fix, done
   localparam int MAX_OPS        = 400;
   localparam int OP_CYCLES      = 40;
   localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES + 200;

   logic    clk;
   logic    rst_n;
   logic    req_valid;
   div_op_t req_op;
   data_t   dividend;
   data_t   divisor;
   logic    flush;
   logic    busy;
   logic    done;
   data_t   result;

   int      cycle;
   int      errors;
   int      done_count;
   int      expected_dones;

   // Request in flight as seen by the monitor
   logic    in_flight;
   logic    expect_idle;
   int      acc_cycle;
   int      exp_lat;
   data_t   exp_res;
   div_op_t exp_op;
   data_t   exp_a;
   data_t   exp_b;

   div_clk_gen #(.PERIOD (8)) u_clk (.clk (clk));

   div_top #(.SMALL_W (SMALL_W)) dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req_op    (req_op),
      .dividend  (dividend),
      .divisor   (divisor),
      .flush     (flush),
      .busy      (busy),
      .done      (done),
      .result    (result)
   );

   // RISC-V division rules
   function automatic data_t ref_div(input div_op_t op, input data_t a, input data_t b);
      logic signed [DIV_W-1:0] sa;
      logic signed [DIV_W-1:0] sb;
      logic                    signed_op;
      logic                    rem_op;
      sa        = a;
      sb        = b;
      signed_op = (op == op_div) || (op == op_rem);
      rem_op    = (op == op_rem) || (op == op_remu);
      if (b == '0) begin
         return rem_op ? a : '1;
      end
      if (signed_op && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
         return rem_op ? '0 : 32'h8000_0000;   // Signed overflow
      end
      if (signed_op) begin
         return rem_op ? data_t'(sa % sb) : data_t'(sa / sb);
      end
      return rem_op ? a % b : a / b;
   endfunction

   function automatic int exp_latency(input div_op_t op, input data_t a, input data_t b);
      logic quot_op;
      quot_op = (op == op_div) || (op == op_divu);
      if (quot_op && a <= SMALL_MAX && b <= SMALL_MAX && b != '0) begin
         return SHORT_LAT;
      end
      return LONG_LAT;
   endfunction

   task automatic wait_idle();
      @(negedge clk);
      while (busy) @(negedge clk);
   endtask

   // Returns at the start of the cycle after the accept
   task automatic start_op(input div_op_t op, input data_t a, input data_t b, input logic fl);
      wait_idle();
      @(posedge clk);
      req_valid <= 1'b1;
      req_op    <= op;
      dividend  <= a;
      divisor   <= b;
      flush     <= fl;
      @(posedge clk);
      req_valid <= 1'b0;
      flush     <= 1'b0;
   endtask

   task automatic run_op(input div_op_t op, input data_t a, input data_t b);
      start_op(op, a, b, 1'b0);
      expected_dones++;
   endtask

   // Flush in cycle T+at of the operation
   task automatic flush_op(input div_op_t op, input data_t a, input data_t b, input int at);
      start_op(op, a, b, at == 0);
      if (at > 0) begin
         repeat (at - 1) @(posedge clk);
         flush <= 1'b1;
         @(posedge clk);
         flush <= 1'b0;
      end
   endtask

   // Cycle counter and timeout
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("errors: %0d", errors + 1);
         $display("TEST FAIL");
         $finish;
      end
   end

   // Compare at each done, mid-cycle where outputs are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (expect_idle && busy) begin
            $display("busy still high the cycle after done or flush (cycle %0d)", cycle);
            errors++;
         end
         expect_idle = 1'b0;
         if (in_flight && !busy) begin
            $display("busy low while an operation is in flight (cycle %0d)", cycle);
            errors++;
         end
         if (done) begin
            done_count++;
            expect_idle = 1'b1;
            if (!in_flight) begin
               $display("done without an accepted request (cycle %0d)", cycle);
               errors++;
            end else begin
               if (result !== exp_res) begin
                  $display("mismatch result: got %h expected %h (op %0d a %h b %h)",
                           result, exp_res, exp_op, exp_a, exp_b);
                  errors++;
               end
               if (cycle - acc_cycle != exp_lat) begin
                  $display("done came %0d cycles after accept instead of %0d",
                           cycle - acc_cycle, exp_lat);
                  errors++;
               end
            end
            in_flight = 1'b0;
         end else if (in_flight && flush) begin
            in_flight   = 1'b0;
            expect_idle = 1'b1;
         end
         if (req_valid && !busy) begin
            if (flush) begin
               expect_idle = 1'b1;   // Dropped in its accept cycle
            end else begin
               in_flight = 1'b1;
               acc_cycle = cycle;
               exp_op    = req_op;
               exp_a     = dividend;
               exp_b     = divisor;
               exp_res   = ref_div(req_op, dividend, divisor);
               exp_lat   = exp_latency(req_op, dividend, divisor);
            end
         end
      end
   end

   initial begin
      div_op_t op;
      data_t   a;
      data_t   b;
      int      sva_fails;
      void'($urandom(52));
      rst_n          = 1'b0;
      req_valid      = 1'b0;
      req_op         = op_div;
      dividend       = '0;
      divisor        = '0;
      flush          = 1'b0;
      errors         = 0;
      done_count     = 0;
      expected_dones = 0;
      in_flight      = 1'b0;
      expect_idle    = 1'b0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      if (busy !== 1'b0 || done !== 1'b0) begin
         $display("mismatch busy/done after reset: got %h/%h expected 0/0", busy, done);
         errors++;
      end
      if (result !== '0) begin
         $display("mismatch result after reset: got %h expected %h", result, 32'h0);
         errors++;
      end

      for (int i = 0; i < 300; i++) begin
         op = div_op_t'($urandom_range(3, 0));
         a  = $urandom;
         b  = $urandom;
         if ($urandom_range(3, 0) == 0) begin
            b = b >> $urandom_range(31, 0);   // Spread divisor sizes
         end
         run_op(op, a, b);
      end

      // Small operands on all four ops
      for (int i = 0; i < 12; i++) begin
         a = (i == 0) ? SMALL_MAX : $urandom_range(SMALL_MAX, 0);
         b = (i == 1) ? SMALL_MAX : $urandom_range(SMALL_MAX, 1);
         for (int k = 0; k < 4; k++) run_op(div_op_t'(k), a, b);
      end

      for (int i = 0; i < 3; i++) begin
         a = (i == 0) ? 32'h7 : (i == 1) ? 32'h8000_0000 : $urandom;
         for (int k = 0; k < 4; k++) run_op(div_op_t'(k), a, '0);
      end
      for (int k = 0; k < 4; k++) run_op(div_op_t'(k), 32'h8000_0000, 32'hffff_ffff);

      for (int i = 0; i < 10; i++) begin
         op = div_op_t'($urandom_range(3, 0));
         a  = $urandom | 32'h0001_0000;   // Never a shortcut
         flush_op(op, a, $urandom, $urandom_range(LONG_LAT - 1, 0));
         run_op(div_op_t'($urandom_range(3, 0)), $urandom, $urandom);
      end
      flush_op(op_div, 32'h9, 32'h2, 1);   // Shortcut dropped in check
      run_op(op_divu, 32'h9, 32'h2);
      flush_op(op_divu, 32'h0012_3456, 32'h0000_0789, LONG_LAT);   // No effect on done
      expected_dones++;

      // Requests during busy must be ignored
      for (int i = 0; i < 10; i++) begin
         op = div_op_t'($urandom_range(3, 0));
         run_op(op, $urandom | 32'h0001_0000, $urandom);
         repeat ($urandom_range(LONG_LAT - 2, 0)) @(posedge clk);
         req_valid <= 1'b1;
         req_op    <= div_op_t'($urandom_range(3, 0));
         dividend  <= $urandom;
         divisor   <= $urandom;
         @(posedge clk);
         req_valid <= 1'b0;
      end

      wait_idle();
      repeat (4) @(negedge clk);
      if (done_count != expected_dones) begin
         $display("saw %0d done pulses but expected %0d", done_count, expected_dones);
         errors++;
      end
      sva_fails = dut.u_control.u_sva.fail_count;
      $display("errors: %0d, assertion failures: %0d, done pulses: %0d",
               errors, sva_fails, done_count);
      if (errors == 0 && sva_fails == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
